/* list.f */
rtl/cache_cfg_pkg.sv
rtl/mem_if_pkg.sv
rtl/flush_sequencer.sv
rtl/l1_req_arbiter.sv
rtl/l2_cache.sv
rtl/core_mem_subsystem.sv
test/core_mem_subsystem_tb.sv

/* run.sh */
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
rm -rf obj_dir sim.log && \
verilator --binary --timing --assert --timescale 1ns/100ps -f list.f \
   --top-module core_mem_subsystem_tb -Mdir obj_dir -o sim && \
./obj_dir/sim > sim.log 2>&1 ; cat sim.log && \
grep -q "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* test/core_mem_subsystem_tb.sv */
`default_nettype none

module core_mem_subsystem_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import cache_cfg_pkg::*;
   import mem_if_pkg::*;

   typedef enum logic [1:0] {
      ACT_SINGLE = 2'd0,
      ACT_PAIR   = 2'd1,  // issued in the same cycle as the next entry
      ACT_FLUSH  = 2'd2
   } action_t;

   typedef struct packed {
      action_t           act;
      l1_client_t        client;  // for a flush the L1 that completes first
      mem_op_t           op;
      logic [ADDR_W-1:0] addr;
      logic [LINE_W-1:0] wdata;
      logic [LINE_W-1:0] exp_data;
      logic              exp_hit;
   } stim_t;

   typedef enum logic [1:0] {
      MEM_IDLE  = 2'd0,
      MEM_DELAY = 2'd1,
      MEM_RESP  = 2'd2
   } mem_phase_t;

   localparam int CLK_PERIOD = 4;
   localparam int N_STIM = 14;
   localparam int CYCLES_PER_STIM = 40;
   localparam int WATCHDOG_NS = (N_STIM + 2) * CYCLES_PER_STIM * CLK_PERIOD;
   localparam int FLUSH_DROP_CYCLES = 11;  // sequencer, start pulse, 8 sets, drop
   localparam logic [ADDR_W-1:0] ADDR_A = 32'h0000_1000;  // set 0
   localparam logic [ADDR_W-1:0] ADDR_B = 32'h0000_2010;  // set 1
   localparam logic [ADDR_W-1:0] ADDR_C = 32'h0000_3020;  // set 2
   localparam logic [ADDR_W-1:0] ADDR_D = 32'h0000_4030;  // set 3
   localparam logic [LINE_W-1:0] DATA_1 = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;
   localparam logic [LINE_W-1:0] DATA_2 = 128'h5a5a_0f0f_c3c3_9696_1357_9bdf_2468_ace0;

   logic clk = 1'b0;
   logic reset;
   logic l1d_req_valid;
   l1_mem_req_t l1d_req;
   logic l1d_req_ack;
   logic l1i_req_valid;
   l1_mem_req_t l1i_req;
   logic l1i_req_ack;
   logic l1d_rsp_valid;
   logic l1i_rsp_valid;
   logic [LINE_W-1:0] l1_rsp_data;
   logic mem_req_valid;
   mem_req_t mem_req;
   logic mem_req_ack = 1'b0;
   logic mem_rsp_valid = 1'b0;
   logic [LINE_W-1:0] mem_rsp_data = '0;
   logic flush_req_l1d;
   logic flush_req_l1i;
   logic l1d_flush_complete;
   logic l1i_flush_complete;
   logic [63:0] l2_cache_accesses;
   logic [63:0] l2_cache_hits;
   logic in_flush_mode;

   stim_t stim_tab [N_STIM];
   logic [LINE_W-1:0] mem_model [logic [ADDR_W-1:0]];
   mem_phase_t mem_phase = MEM_IDLE;
   int unsigned mem_delay = 0;
   int mem_req_count = 0;
   l1_client_t last_served = CLIENT_L1I;
   int error_count = 0;
   int i;

   core_mem_subsystem core_mem_subsystem_inst
     (
      .clk(clk),
      .reset(reset),
      .l1d_req_valid(l1d_req_valid),
      .l1d_req(l1d_req),
      .l1d_req_ack(l1d_req_ack),
      .l1i_req_valid(l1i_req_valid),
      .l1i_req(l1i_req),
      .l1i_req_ack(l1i_req_ack),
      .l1d_rsp_valid(l1d_rsp_valid),
      .l1i_rsp_valid(l1i_rsp_valid),
      .l1_rsp_data(l1_rsp_data),
      .mem_req_valid(mem_req_valid),
      .mem_req(mem_req),
      .mem_req_ack(mem_req_ack),
      .mem_rsp_valid(mem_rsp_valid),
      .mem_rsp_data(mem_rsp_data),
      .flush_req_l1d(flush_req_l1d),
      .flush_req_l1i(flush_req_l1i),
      .l1d_flush_complete(l1d_flush_complete),
      .l1i_flush_complete(l1i_flush_complete),
      .l2_cache_accesses(l2_cache_accesses),
      .l2_cache_hits(l2_cache_hits),
      .in_flush_mode(in_flush_mode)
      );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic stop_on_failure();
      $display("tests failed");
      $fatal(1, "simulation stopped after an error");
   endtask

   task automatic check_value(input string name, input logic [LINE_W-1:0] actual,
                              input logic [LINE_W-1:0] expected);
      if (actual !== expected)
      begin
         error_count++;
         $display("[ERROR] %0d ns %s: got %h, expected %h", $time, name, actual, expected);
         stop_on_failure();
      end
   endtask

   // unwritten lines read back as their address four times
   function automatic logic [LINE_W-1:0] read_line(input logic [ADDR_W-1:0] a);
      if (mem_model.exists(a))
         return mem_model[a];
      return {4{a}};
   endfunction

   function automatic stim_t make_stim(input action_t act, input l1_client_t c,
                                       input mem_op_t op, input logic [ADDR_W-1:0] a,
                                       input logic [LINE_W-1:0] wd,
                                       input logic [LINE_W-1:0] ed, input logic h);
      return '{act: act, client: c, op: op, addr: a, wdata: wd, exp_data: ed, exp_hit: h};
   endfunction

   task automatic load_table();
      stim_tab[0] = make_stim(ACT_SINGLE, CLIENT_L1D, MEM_LOAD, ADDR_A, '0, {4{ADDR_A}}, 1'b0);
      stim_tab[1] = make_stim(ACT_SINGLE, CLIENT_L1D, MEM_LOAD, ADDR_A, '0, {4{ADDR_A}}, 1'b1);
      stim_tab[2] = make_stim(ACT_SINGLE, CLIENT_L1D, MEM_STORE, ADDR_A, DATA_1, DATA_1, 1'b1);
      stim_tab[3] = make_stim(ACT_SINGLE, CLIENT_L1D, MEM_LOAD, ADDR_A, '0, DATA_1, 1'b1);
      stim_tab[4] = make_stim(ACT_PAIR, CLIENT_L1D, MEM_LOAD, ADDR_B, '0, {4{ADDR_B}}, 1'b0);
      stim_tab[5] = make_stim(ACT_SINGLE, CLIENT_L1I, MEM_LOAD, ADDR_C, '0, {4{ADDR_C}}, 1'b0);
      stim_tab[6] = make_stim(ACT_PAIR, CLIENT_L1I, MEM_LOAD, ADDR_C, '0, {4{ADDR_C}}, 1'b1);
      stim_tab[7] = make_stim(ACT_SINGLE, CLIENT_L1D, MEM_LOAD, ADDR_B, '0, {4{ADDR_B}}, 1'b1);
      stim_tab[8] = make_stim(ACT_SINGLE, CLIENT_L1D, MEM_STORE, ADDR_D, DATA_2, DATA_2, 1'b0);
      stim_tab[9] = make_stim(ACT_SINGLE, CLIENT_L1D, MEM_LOAD, ADDR_D, '0, DATA_2, 1'b0);
      stim_tab[10] = make_stim(ACT_FLUSH, CLIENT_L1D, MEM_LOAD, '0, '0, '0, 1'b0);
      stim_tab[11] = make_stim(ACT_SINGLE, CLIENT_L1D, MEM_LOAD, ADDR_A, '0, DATA_1, 1'b0);
      stim_tab[12] = make_stim(ACT_FLUSH, CLIENT_L1I, MEM_LOAD, '0, '0, '0, 1'b0);
      stim_tab[13] = make_stim(ACT_SINGLE, CLIENT_L1I, MEM_LOAD, ADDR_A, '0, DATA_1, 1'b0);
   endtask

   task automatic check_response(input l1_client_t c, input int idx, input int got,
                                 input int n, input l1_client_t first_exp);
      if (idx < 0)
      begin
         $display("response at %0d ns went to a client with no request outstanding", $time);
         stop_on_failure();
      end
      else
      begin
         if ((n == 2) && (got == 0))
            check_value("first responding client", LINE_W'(c), LINE_W'(first_exp));
         check_value("l1_rsp_data", l1_rsp_data, stim_tab[idx].exp_data);
         last_served = c;
      end
   endtask

   // issue n entries in the same cycle and collect their responses
   task automatic do_access(input int first, input int n);
      int idx_d;
      int idx_i;
      int got;
      int k;
      int exp_hits;
      int exp_mem;
      int mem_before;
      logic [63:0] acc_before;
      logic [63:0] hit_before;
      stim_t e;
      l1_client_t first_exp;
      idx_d = -1;
      idx_i = -1;
      exp_hits = 0;
      exp_mem = 0;
      first_exp = (last_served == CLIENT_L1D) ? CLIENT_L1I : CLIENT_L1D;
      @(posedge clk);
      acc_before = l2_cache_accesses;
      hit_before = l2_cache_hits;
      mem_before = mem_req_count;
      for (k = first; k < first + n; k++)
      begin
         e = stim_tab[k];
         exp_hits += int'(e.exp_hit);
         if ((e.op == MEM_STORE) || !e.exp_hit)
            exp_mem += 1;  // write-through or fill
         if (e.client == CLIENT_L1D)
         begin
            idx_d = k;
            l1d_req_valid <= 1'b1;
            l1d_req <= '{addr: e.addr, op: e.op, data: e.wdata};
         end
         else
         begin
            idx_i = k;
            l1i_req_valid <= 1'b1;
            l1i_req <= '{addr: e.addr, op: e.op, data: e.wdata};
         end
      end
      got = 0;
      while (got < n)
      begin
         @(posedge clk);
         if (l1d_req_ack)
            l1d_req_valid <= 1'b0;
         if (l1i_req_ack)
            l1i_req_valid <= 1'b0;
         if (l1d_rsp_valid)
         begin
            check_response(CLIENT_L1D, idx_d, got, n, first_exp);
            got++;
         end
         if (l1i_rsp_valid)
         begin
            check_response(CLIENT_L1I, idx_i, got, n, first_exp);
            got++;
         end
      end
      check_value("l2_cache_accesses delta", LINE_W'(l2_cache_accesses - acc_before), LINE_W'(n));
      check_value("l2_cache_hits delta", LINE_W'(l2_cache_hits - hit_before), LINE_W'(exp_hits));
      check_value("mem requests", LINE_W'(mem_req_count - mem_before), LINE_W'(exp_mem));
      for (k = first; k < first + n; k++)
         if (stim_tab[k].op == MEM_STORE)
            check_value("memory line", read_line(stim_tab[k].addr), stim_tab[k].wdata);
   endtask

   task automatic do_flush(input l1_client_t first_done);
      int k;
      @(posedge clk);
      flush_req_l1d <= 1'b1;
      @(posedge clk);
      flush_req_l1d <= 1'b0;
      flush_req_l1i <= 1'b1;
      @(posedge clk);
      flush_req_l1i <= 1'b0;
      check_value("in_flush_mode", LINE_W'(in_flush_mode), LINE_W'(1));
      if (first_done == CLIENT_L1D)
         l1d_flush_complete <= 1'b1;
      else
         l1i_flush_complete <= 1'b1;
      @(posedge clk);
      l1d_flush_complete <= 1'b0;
      l1i_flush_complete <= 1'b0;
      repeat (3) @(posedge clk);
      check_value("in_flush_mode", LINE_W'(in_flush_mode), LINE_W'(1));
      if (first_done == CLIENT_L1D)
         l1i_flush_complete <= 1'b1;
      else
         l1d_flush_complete <= 1'b1;
      for (k = 1; k <= FLUSH_DROP_CYCLES; k++)
      begin
         @(posedge clk);
         l1d_flush_complete <= 1'b0;
         l1i_flush_complete <= 1'b0;
         check_value("in_flush_mode", LINE_W'(in_flush_mode), LINE_W'(k < FLUSH_DROP_CYCLES));
      end
   endtask

   // memory model, accepts after 0 to 3 extra cycles
   always @(posedge clk)
   begin
      mem_req_ack <= 1'b0;
      mem_rsp_valid <= 1'b0;
      if (reset)
         mem_phase <= MEM_IDLE;
      else
         case (mem_phase)
            MEM_IDLE:
               if (mem_req_valid)
               begin
                  mem_delay <= $urandom % 4;
                  mem_phase <= MEM_DELAY;
               end
            MEM_DELAY:
               if (mem_delay == 0)
               begin
                  mem_req_ack <= 1'b1;
                  mem_req_count <= mem_req_count + 1;
                  if (mem_req.op == MEM_STORE)
                     mem_model[mem_req.addr] = mem_req.data;
                  mem_rsp_data <= read_line(mem_req.addr);
                  mem_phase <= MEM_RESP;
               end
               else
                  mem_delay <= mem_delay - 1;
            MEM_RESP:
            begin
               mem_rsp_valid <= 1'b1;  // load data or write ack
               mem_phase <= MEM_IDLE;
            end
            default:
               mem_phase <= MEM_IDLE;
         endcase
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("timeout after %0d ns, the DUT stopped responding", WATCHDOG_NS);
      stop_on_failure();
   end

   initial
   begin
      void'($urandom(25));
      reset <= 1'b1;
      l1d_req_valid <= 1'b0;
      l1i_req_valid <= 1'b0;
      l1d_req <= '0;
      l1i_req <= '0;
      flush_req_l1d <= 1'b0;
      flush_req_l1i <= 1'b0;
      l1d_flush_complete <= 1'b0;
      l1i_flush_complete <= 1'b0;
      load_table();
      repeat (2) @(posedge clk);
      check_value("in_flush_mode", LINE_W'(in_flush_mode), '0);
      check_value("mem_req_valid", LINE_W'(mem_req_valid), '0);
      check_value("ack and rsp_valid", LINE_W'({l1d_req_ack, l1i_req_ack,
                                               l1d_rsp_valid, l1i_rsp_valid}), '0);
      check_value("l2 counters", {l2_cache_accesses, l2_cache_hits}, '0);
      reset <= 1'b0;
      i = 0;
      while (i < N_STIM)
      begin
         case (stim_tab[i].act)
            ACT_PAIR:
            begin
               do_access(i, 2);
               i += 2;
            end
            ACT_FLUSH:
            begin
               do_flush(stim_tab[i].client);
               i += 1;
            end
            default:
            begin
               do_access(i, 1);
               i += 1;
            end
         endcase
      end
      repeat (2) @(posedge clk);
      if (error_count == 0)
      begin
         $display("all tests passed");
         $finish;
      end
      else
         stop_on_failure();
   end

endmodule

`default_nettype wire

/* rtl/core_mem_subsystem.sv */
`default_nettype none

module core_mem_subsystem
  (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             l1d_req_valid,
   input  mem_if_pkg::l1_mem_req_t          l1d_req,
   output logic                             l1d_req_ack,
   input  logic                             l1i_req_valid,
   input  mem_if_pkg::l1_mem_req_t          l1i_req,
   output logic                             l1i_req_ack,
   output logic                             l1d_rsp_valid,
   output logic                             l1i_rsp_valid,
   output logic [cache_cfg_pkg::LINE_W-1:0] l1_rsp_data,
   output logic                             mem_req_valid,
   output mem_if_pkg::mem_req_t             mem_req,
   input  logic                             mem_req_ack,
   input  logic                             mem_rsp_valid,
   input  logic [cache_cfg_pkg::LINE_W-1:0] mem_rsp_data,
   input  logic                             flush_req_l1d,
   input  logic                             flush_req_l1i,
   input  logic                             l1d_flush_complete,
   input  logic                             l1i_flush_complete,
   output logic [63:0]                      l2_cache_accesses,
   output logic [63:0]                      l2_cache_hits,
   output logic                             in_flush_mode
   );
   import cache_cfg_pkg::*;
   import mem_if_pkg::*;

   logic l2_req_valid;
   l1_mem_req_t l2_req;
   logic l2_req_ack;
   logic l2_rsp_valid;
   logic [LINE_W-1:0] l2_rsp_data;
   logic l2_flush_start;
   logic l2_flush_complete;

   l1_req_arbiter l1_req_arbiter_inst
     (
      .clk(clk),
      .reset(reset),
      .l1d_req_valid(l1d_req_valid),
      .l1i_req_valid(l1i_req_valid),
      .l1d_req(l1d_req),
      .l1i_req(l1i_req),
      .l1d_req_ack(l1d_req_ack),
      .l1i_req_ack(l1i_req_ack),
      .l1d_rsp_valid(l1d_rsp_valid),
      .l1i_rsp_valid(l1i_rsp_valid),
      .l1_rsp_data(l1_rsp_data),
      .l2_req_valid(l2_req_valid),
      .l2_req(l2_req),
      .l2_req_ack(l2_req_ack),
      .l2_rsp_valid(l2_rsp_valid),
      .l2_rsp_data(l2_rsp_data)
      );

   l2_cache l2_cache_inst
     (
      .clk(clk),
      .reset(reset),
      .l2_req_valid(l2_req_valid),
      .l2_req(l2_req),
      .l2_req_ack(l2_req_ack),
      .l2_rsp_valid(l2_rsp_valid),
      .l2_rsp_data(l2_rsp_data),
      .l2_flush_start(l2_flush_start),
      .l2_flush_complete(l2_flush_complete),
      .mem_req_valid(mem_req_valid),
      .mem_req(mem_req),
      .mem_req_ack(mem_req_ack),
      .mem_rsp_valid(mem_rsp_valid),
      .mem_rsp_data(mem_rsp_data),
      .cache_accesses(l2_cache_accesses),
      .cache_hits(l2_cache_hits)
      );

   flush_sequencer flush_sequencer_inst
     (
      .clk(clk),
      .reset(reset),
      .flush_req_l1d(flush_req_l1d),
      .flush_req_l1i(flush_req_l1i),
      .l1d_flush_complete(l1d_flush_complete),
      .l1i_flush_complete(l1i_flush_complete),
      .l2_flush_complete(l2_flush_complete),
      .l2_flush_start(l2_flush_start),
      .in_flush_mode(in_flush_mode)
      );

endmodule

`default_nettype wire

/* rtl/l2_cache.sv */
`default_nettype none

module l2_cache
  (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             l2_req_valid,
   input  mem_if_pkg::l1_mem_req_t          l2_req,
   output logic                             l2_req_ack,
   output logic                             l2_rsp_valid,
   output logic [cache_cfg_pkg::LINE_W-1:0] l2_rsp_data,
   input  logic                             l2_flush_start,
   output logic                             l2_flush_complete,
   output logic                             mem_req_valid,
   output mem_if_pkg::mem_req_t             mem_req,
   input  logic                             mem_req_ack,
   input  logic                             mem_rsp_valid,
   input  logic [cache_cfg_pkg::LINE_W-1:0] mem_rsp_data,
   output logic [63:0]                      cache_accesses,
   output logic [63:0]                      cache_hits
   );
   import cache_cfg_pkg::*;
   import mem_if_pkg::*;

   typedef enum logic [2:0] {
      IDLE     = 3'd0,
      LOOKUP   = 3'd1,
      MEM_REQ  = 3'd2,
      MEM_WAIT = 3'd3,
      RESPOND  = 3'd4,
      FLUSH    = 3'd5
   } state_t;

   state_t r_state;
   l1_mem_req_t r_req;
   logic [L2_SETS-1:0] r_valid;
   logic [TAG_W-1:0] r_tag [L2_SETS];
   logic [LINE_W-1:0] r_line [L2_SETS];
   logic [LINE_W-1:0] r_rsp_data;
   logic [LG_L2_SETS-1:0] r_flush_idx;
   logic r_flush_pend;  // start seen while busy
   logic [63:0] r_accesses;
   logic [63:0] r_hits;

   logic [LG_L2_SETS-1:0] w_idx;
   logic [TAG_W-1:0] w_tag;
   logic w_hit;
   logic w_flush_go;
   logic w_accept;

   assign w_idx = r_req.addr[LG_LINE_BYTES +: LG_L2_SETS];
   assign w_tag = r_req.addr[ADDR_W-1 -: TAG_W];
   assign w_hit = r_valid[w_idx] && (r_tag[w_idx] == w_tag);

   // a pending flush beats a new request
   assign w_flush_go = (r_state == IDLE) && (l2_flush_start || r_flush_pend);
   assign w_accept = (r_state == IDLE) && l2_req_valid && !l2_flush_start && !r_flush_pend;

   assign l2_req_ack = w_accept;
   assign l2_rsp_valid = (r_state == RESPOND);
   assign l2_rsp_data = r_rsp_data;
   assign l2_flush_complete = (r_state == FLUSH) && (&r_flush_idx);
   assign mem_req_valid = (r_state == MEM_REQ);
   assign mem_req = '{addr: r_req.addr, op: r_req.op, data: r_req.data};
   assign cache_accesses = r_accesses;
   assign cache_hits = r_hits;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= IDLE;
         r_valid <= '0;
         r_flush_idx <= '0;
         r_flush_pend <= 1'b0;
         r_accesses <= 64'd0;
         r_hits <= 64'd0;
      end
      else
      begin
         r_flush_pend <= (r_flush_pend || l2_flush_start) && !w_flush_go;
         case (r_state)
            IDLE:
            begin
               if (w_flush_go)
               begin
                  r_state <= FLUSH;
                  r_flush_idx <= '0;
               end
               else if (w_accept)
               begin
                  r_state <= LOOKUP;
                  r_accesses <= r_accesses + 64'd1;
               end
            end
            LOOKUP:
            begin
               if (w_hit)
                  r_hits <= r_hits + 64'd1;
               // stores always go out to memory
               r_state <= (w_hit && (r_req.op == MEM_LOAD)) ? RESPOND : MEM_REQ;
            end
            MEM_REQ:
               if (mem_req_ack)
                  r_state <= MEM_WAIT;
            MEM_WAIT:
            begin
               if (mem_rsp_valid)
               begin
                  r_state <= RESPOND;
                  if (r_req.op == MEM_LOAD)
                     r_valid[w_idx] <= 1'b1;
               end
            end
            RESPOND:
               r_state <= IDLE;
            FLUSH:
            begin
               r_valid[r_flush_idx] <= 1'b0;  // one set per cycle
               r_flush_idx <= r_flush_idx + 1'b1;
               if (&r_flush_idx)
                  r_state <= IDLE;
            end
            default:
               r_state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (w_accept)
         r_req <= l2_req;
      case (r_state)
         LOOKUP:
         begin
            if (r_req.op == MEM_STORE)
            begin
               r_rsp_data <= r_req.data;
               if (w_hit)
                  r_line[w_idx] <= r_req.data;  // no allocate on miss
            end
            else
               r_rsp_data <= r_line[w_idx];
         end
         MEM_WAIT:
         begin
            if (mem_rsp_valid && (r_req.op == MEM_LOAD))
            begin
               r_tag[w_idx] <= w_tag;
               r_line[w_idx] <= mem_rsp_data;
               r_rsp_data <= mem_rsp_data;
            end
         end
         default:
         begin
         end
      endcase
   end

endmodule

`default_nettype wire

/* rtl/l1_req_arbiter.sv */
`default_nettype none

module l1_req_arbiter
  (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             l1d_req_valid,
   input  logic                             l1i_req_valid,
   input  mem_if_pkg::l1_mem_req_t          l1d_req,
   input  mem_if_pkg::l1_mem_req_t          l1i_req,
   output logic                             l1d_req_ack,
   output logic                             l1i_req_ack,
   output logic                             l1d_rsp_valid,
   output logic                             l1i_rsp_valid,
   output logic [cache_cfg_pkg::LINE_W-1:0] l1_rsp_data,
   output logic                             l2_req_valid,
   output mem_if_pkg::l1_mem_req_t          l2_req,
   input  logic                             l2_req_ack,
   input  logic                             l2_rsp_valid,
   input  logic [cache_cfg_pkg::LINE_W-1:0] l2_rsp_data
   );
   import mem_if_pkg::*;

   typedef enum logic [1:0] {
      IDLE    = 2'd0,
      GNT_L1D = 2'd1,
      GNT_L1I = 2'd2
   } state_t;

   state_t r_state;
   l1_client_t r_last_gnt;
   logic r_l2_req_valid;
   logic r_l1d_ack;
   logic r_l1i_ack;
   l1_mem_req_t r_req;
   logic w_pick_l1d;
   logic w_pick_l1i;

   // on a tie the client not served last wins
   assign w_pick_l1d = l1d_req_valid && (!l1i_req_valid || (r_last_gnt == CLIENT_L1I));
   assign w_pick_l1i = l1i_req_valid && !w_pick_l1d;

   assign l1d_req_ack = r_l1d_ack;
   assign l1i_req_ack = r_l1i_ack;
   assign l2_req_valid = r_l2_req_valid;
   assign l2_req = r_req;

   // response goes straight through to the granted client
   assign l1d_rsp_valid = (r_state == GNT_L1D) && l2_rsp_valid;
   assign l1i_rsp_valid = (r_state == GNT_L1I) && l2_rsp_valid;
   assign l1_rsp_data = l2_rsp_data;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= IDLE;
         r_last_gnt <= CLIENT_L1I;  // first tie goes to l1d
         r_l2_req_valid <= 1'b0;
         r_l1d_ack <= 1'b0;
         r_l1i_ack <= 1'b0;
      end
      else
      begin
         r_l1d_ack <= (r_state == IDLE) && w_pick_l1d;
         r_l1i_ack <= (r_state == IDLE) && w_pick_l1i;
         case (r_state)
            IDLE:
            begin
               if (w_pick_l1d)
               begin
                  r_state <= GNT_L1D;
                  r_last_gnt <= CLIENT_L1D;
                  r_l2_req_valid <= 1'b1;
               end
               else if (w_pick_l1i)
               begin
                  r_state <= GNT_L1I;
                  r_last_gnt <= CLIENT_L1I;
                  r_l2_req_valid <= 1'b1;
               end
            end
            GNT_L1D, GNT_L1I:
            begin
               if (l2_req_ack)
                  r_l2_req_valid <= 1'b0;
               if (l2_rsp_valid)
                  r_state <= IDLE;
            end
            default:
               r_state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if ((r_state == IDLE) && (w_pick_l1d || w_pick_l1i))
         r_req <= w_pick_l1d ? l1d_req : l1i_req;
   end

   a_rsp_onehot: assert property (@(posedge clk) disable iff (reset)
      !(l1d_rsp_valid && l1i_rsp_valid));

   // request held steady until the L2 takes it
   a_req_hold: assert property (@(posedge clk) disable iff (reset)
      (l2_req_valid && !l2_req_ack) |=> (l2_req_valid && $stable(l2_req)));

endmodule

`default_nettype wire

/* rtl/flush_sequencer.sv */
`default_nettype none

module flush_sequencer
  (
   input  logic clk,
   input  logic reset,
   input  logic flush_req_l1d,
   input  logic flush_req_l1i,
   input  logic l1d_flush_complete,
   input  logic l1i_flush_complete,
   input  logic l2_flush_complete,
   output logic l2_flush_start,
   output logic in_flush_mode
   );

   typedef enum logic [2:0] {
      FLUSH_IDLE       = 3'd0,
      WAIT_FOR_L1D_L1I = 3'd1,
      GOT_L1D          = 3'd2,
      GOT_L1I          = 3'd3,
      FLUSH_L2         = 3'd4
   } flush_state_t;

   flush_state_t r_state, n_state;
   logic r_flush, n_flush;
   logic r_flush_l2, n_flush_l2;

   assign in_flush_mode = r_flush;
   assign l2_flush_start = r_flush_l2;

   always_comb
   begin
      n_state = r_state;
      n_flush = r_flush;
      n_flush_l2 = 1'b0;
      case (r_state)
         FLUSH_IDLE:
         begin
            if (flush_req_l1d || flush_req_l1i)
            begin
               n_state = WAIT_FOR_L1D_L1I;
               n_flush = 1'b1;
            end
         end
         WAIT_FOR_L1D_L1I:
         begin
            if (l1d_flush_complete && l1i_flush_complete)
            begin
               n_state = FLUSH_L2;
               n_flush_l2 = 1'b1;
            end
            else if (l1d_flush_complete)
               n_state = GOT_L1D;
            else if (l1i_flush_complete)
               n_state = GOT_L1I;
         end
         GOT_L1D:  // still missing l1i
         begin
            if (l1i_flush_complete)
            begin
               n_state = FLUSH_L2;
               n_flush_l2 = 1'b1;
            end
         end
         GOT_L1I:
         begin
            if (l1d_flush_complete)
            begin
               n_state = FLUSH_L2;
               n_flush_l2 = 1'b1;
            end
         end
         FLUSH_L2:
         begin
            if (l2_flush_complete)
            begin
               n_state = FLUSH_IDLE;
               n_flush = 1'b0;  // drops next cycle
            end
         end
         default:
            n_state = FLUSH_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= FLUSH_IDLE;
         r_flush <= 1'b0;
         r_flush_l2 <= 1'b0;
      end
      else
      begin
         r_state <= n_state;
         r_flush <= n_flush;
         r_flush_l2 <= n_flush_l2;
      end
   end

   // start pulse only on the first cycle in FLUSH_L2
   a_start_on_entry: assert property (@(posedge clk) disable iff (reset)
      l2_flush_start |-> (r_state == FLUSH_L2) && ($past(r_state) != FLUSH_L2));

endmodule

`default_nettype wire

/* rtl/mem_if_pkg.sv */
`default_nettype none

package mem_if_pkg;
   import cache_cfg_pkg::*;

   typedef enum logic [3:0] {
      MEM_LOAD  = 4'd0,
      MEM_STORE = 4'd1
   } mem_op_t;

   // line request from either L1
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      mem_op_t           op;
      logic [LINE_W-1:0] data;  // store data only
   } l1_mem_req_t;

   // request to external memory
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      mem_op_t           op;
      logic [LINE_W-1:0] data;
   } mem_req_t;

   typedef enum logic {
      CLIENT_L1D = 1'b0,
      CLIENT_L1I = 1'b1
   } l1_client_t;

endpackage

`default_nettype wire

/* rtl/cache_cfg_pkg.sv */
`default_nettype none

package cache_cfg_pkg;

   localparam int ADDR_W = 32;
   localparam int LG_LINE_BYTES = 4;  // 16 byte lines
   localparam int LINE_W = 128;
   localparam int LG_L2_SETS = 3;
   localparam int L2_SETS = 1 << LG_L2_SETS;
   localparam int TAG_W = ADDR_W - LG_L2_SETS - LG_LINE_BYTES;

endpackage

`default_nettype wire
